/* ahbApbBridge.sv */
/*
 * AHB-Lite to APB bridge
 * Accepts one AHB-Lite transfer at a time and runs it as an APB
 * SETUP/ACCESS sequence. Decodes the address slot into a one-hot PSEL,
 * leaving every bit low for slots without a timer. Inserts two wait
 * states plus one per cycle of PREADY low.
 */
`timescale 1ns/10ps
`default_nettype none

`include "apbTimerSys_consts.svh"

module ahbApbBridge #(
    parameter int NumTimers = `NUM_TIMERS_DEF
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,

    // AHB-Lite slave side
    input  logic                    hsel_i,
    input  apbTimerSysPkg::dataT    haddr_i,
    input  logic [1:0]              htrans_i,
    input  logic                    hwrite_i,
    input  logic                    hready_i,
    input  apbTimerSysPkg::dataT    hwdata_i,
    output apbTimerSysPkg::dataT    hrdata_o,
    output logic                    hreadyout_o,

    // APB master side
    output apbTimerSysPkg::dataT    paddr_o,
    output logic                    pwrite_o,
    output apbTimerSysPkg::dataT    pwdata_o,
    output logic                    penable_o,
    output logic [NumTimers-1:0]    psel_o,
    input  apbTimerSysPkg::dataT    prdata_i,
    input  logic                    pready_i
);

    typedef enum logic [1:0] {
        StIdle,
        StSetup,
        StAccess
    } stateT;

    stateT                      state;
    stateT                      stateNext;
    logic                       accept;
    apbTimerSysPkg::slotIdxT    slot;
    logic [`NUM_SLOTS-1:0]      slotDec;
    logic [NumTimers-1:0]       pselReg;
    logic                       writeReg;
    logic [`APB_ADDR_W-1:0]     addrReg;
    apbTimerSysPkg::dataT       wdataReg;
    apbTimerSysPkg::dataT       rdataReg;

    // NONSEQ or SEQ with the slave selected and the bus free
    assign accept = hsel_i & hready_i & htrans_i[1];

    // One-hot slot decode, upper slots fall off the populated range
    assign slot    = haddr_i[`SLOT_MSB:`SLOT_LSB];
    assign slotDec = `NUM_SLOTS'(1) << slot;

    always_comb begin
        stateNext = state;
        case (state)
            StIdle: begin
                if (accept) begin
                    stateNext = StSetup;
                end
            end
            StSetup: begin
                stateNext = StAccess;
            end
            StAccess: begin
                if (pready_i) begin
                    stateNext = StIdle;
                end
            end
            default: begin
                stateNext = StIdle;
            end
        endcase
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state    <= StIdle;
            pselReg  <= '0;
            writeReg <= 1'b0;
        end else begin
            state <= stateNext;
            if (state == StIdle && accept) begin
                pselReg  <= slotDec[NumTimers-1:0];
                writeReg <= hwrite_i;
            end
        end
    end

    // Address and data payload
    always_ff @(posedge HCLK) begin
        if (state == StIdle && accept) begin
            addrReg <= haddr_i;
        end
        // HWDATA belongs to the cycle after the address phase
        if (state == StSetup) begin
            wdataReg <= hwdata_i;
        end
        if (state == StAccess && pready_i && !writeReg) begin
            rdataReg <= prdata_i;
        end
    end

    assign hreadyout_o = (state == StIdle);
    assign hrdata_o    = rdataReg;

    assign paddr_o   = addrReg;
    assign pwrite_o  = writeReg;
    // Write data is live during SETUP and held through ACCESS
    assign pwdata_o  = (state == StSetup) ? hwdata_i : wdataReg;
    assign penable_o = (state == StAccess);
    assign psel_o    = (state == StIdle) ? '0 : pselReg;

endmodule

`default_nettype wire

/* apbReadMux.sv */
/*
 * APB read-back multiplexer
 * AND-OR selection of read data and ready from the timer row, using
 * the bridge's one-hot PSEL. No select answers zero data and ready.
 */
`timescale 1ns/10ps
`default_nettype none

module apbReadMux #(
    parameter int NumTimers = 4
) (
    input  logic [NumTimers-1:0]                    psel_i,
    input  apbTimerSysPkg::dataT [NumTimers-1:0]    prdataVec_i,
    input  logic [NumTimers-1:0]                    preadyVec_i,
    output apbTimerSysPkg::dataT                    prdata_o,
    output logic                                    pready_o
);

    apbTimerSysPkg::dataT dataOr;

    always_comb begin
        dataOr = '0;
        for (int i = 0; i < NumTimers; i++) begin
            dataOr = dataOr | (prdataVec_i[i] & {$bits(apbTimerSysPkg::dataT){psel_i[i]}});
        end
    end

    assign prdata_o = dataOr;

    // Unmapped slot, nobody selected, so complete at once
    assign pready_o = ~(|psel_i) | (|(psel_i & preadyVec_i));

endmodule

`default_nettype wire

/* apbTimer.sv */
/*
 * APB 32-bit timer
 * Prescaled up-counter that wraps at a compare value and sets a sticky
 * overflow flag. The flag drives the interrupt when enabled. Registers
 * are written at the APB ACCESS edge and read back combinationally.
 */
`timescale 1ns/10ps
`default_nettype none

`include "apbTimerSys_consts.svh"

module apbTimer (
    input  logic                    HCLK,
    input  logic                    HRESETn,

    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  apbTimerSysPkg::dataT    paddr_i,
    input  apbTimerSysPkg::dataT    pwdata_i,
    output apbTimerSysPkg::dataT    prdata_o,
    output logic                    pready_o,

    output logic                    irq_o
);

    apbTimerSysPkg::regIdxT regIdx;
    apbTimerSysPkg::dataT   tmr;
    apbTimerSysPkg::dataT   pre;
    apbTimerSysPkg::dataT   cmp;
    apbTimerSysPkg::dataT   preCnt;
    logic                   en;
    logic                   irqEn;
    logic                   ovf;
    logic                   wrEn;
    logic                   tick;
    logic                   wrap;
    logic                   ovfClr;

    assign regIdx = paddr_i[`REG_MSB:`REG_LSB];
    assign wrEn   = psel_i & penable_i & pwrite_i;

    // One tick every PRE+1 cycles while enabled
    assign tick = en && (preCnt == pre);

    // Compare lowered below the count still wraps on the next tick
    assign wrap = tick && (tmr >= cmp);

    assign ovfClr = wrEn && (regIdx == apbTimerSysPkg::regIdxT'(`REG_OVF)) && pwdata_i[0];

    // Software-written registers
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            pre   <= '0;
            cmp   <= '0;
            en    <= 1'b0;
            irqEn <= 1'b0;
        end else if (wrEn) begin
            case (regIdx)
                `REG_PRE: begin
                    pre <= pwdata_i;
                end
                `REG_CMP: begin
                    cmp <= pwdata_i;
                end
                `REG_EN: begin
                    en <= pwdata_i[0];
                end
                `REG_IRQEN: begin
                    irqEn <= pwdata_i[0];
                end
                default: begin
                end
            endcase
        end
    end

    // Prescaler, main counter and overflow flag
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preCnt <= '0;
            tmr    <= '0;
            ovf    <= 1'b0;
        end else begin
            if (!en || tick) begin
                preCnt <= '0;
            end else begin
                preCnt <= preCnt + 1'b1;
            end

            if (wrap) begin
                tmr <= '0;
            end else if (tick) begin
                tmr <= tmr + 1'b1;
            end

            // A set in the same cycle wins over the clear
            ovf <= wrap | (ovf & ~ovfClr);
        end
    end

    always_comb begin
        case (regIdx)
            `REG_TMR:   prdata_o = tmr;
            `REG_PRE:   prdata_o = pre;
            `REG_CMP:   prdata_o = cmp;
            `REG_OVF:   prdata_o = apbTimerSysPkg::dataT'(ovf);
            `REG_EN:    prdata_o = apbTimerSysPkg::dataT'(en);
            `REG_IRQEN: prdata_o = apbTimerSysPkg::dataT'(irqEn);
            default:    prdata_o = '0;
        endcase
    end

    assign pready_o = 1'b1;
    assign irq_o    = ovf & irqEn;

endmodule

`default_nettype wire

/* apbTimerSys.f */
+incdir+.
apbTimerSysPkg.sv
ahbApbBridge.sv
apbTimer.sv
apbReadMux.sv
apbTimerSys.sv
tbApbTimerSys.sv

/* apbTimerSys.sv */
/*
 * APB timer subsystem
 * AHB-Lite slave with an APB bridge feeding a row of 32-bit timers,
 * one per address slot, each with its own interrupt line.
 */
`timescale 1ns/10ps
`default_nettype none

`include "apbTimerSys_consts.svh"

module apbTimerSys #(
    parameter int NumTimers = `NUM_TIMERS_DEF
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,

    input  logic                    hsel_i,
    input  apbTimerSysPkg::dataT    haddr_i,
    input  logic [1:0]              htrans_i,
    input  logic                    hwrite_i,
    input  logic                    hready_i,
    input  apbTimerSysPkg::dataT    hwdata_i,
    output apbTimerSysPkg::dataT    hrdata_o,
    output logic                    hreadyout_o,

    output logic [NumTimers-1:0]    irq_o
);

    apbTimerSysPkg::dataT                   paddr;
    logic                                   pwrite;
    apbTimerSysPkg::dataT                   pwdata;
    logic                                   penable;
    logic [NumTimers-1:0]                   psel;
    apbTimerSysPkg::dataT                   prdata;
    logic                                   pready;
    apbTimerSysPkg::dataT [NumTimers-1:0]   prdataVec;
    logic [NumTimers-1:0]                   preadyVec;

    ahbApbBridge #(
        .NumTimers  (NumTimers)
    ) ahbApbBridge_i (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .hsel_i      (hsel_i),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hwrite_i    (hwrite_i),
        .hready_i    (hready_i),
        .hwdata_i    (hwdata_i),
        .hrdata_o    (hrdata_o),
        .hreadyout_o (hreadyout_o),
        .paddr_o     (paddr),
        .pwrite_o    (pwrite),
        .pwdata_o    (pwdata),
        .penable_o   (penable),
        .psel_o      (psel),
        .prdata_i    (prdata),
        .pready_i    (pready)
    );

    // One timer per populated slot
    for (genvar i = 0; i < NumTimers; i++) begin : genTimer
        apbTimer apbTimer_i (
            .HCLK      (HCLK),
            .HRESETn   (HRESETn),
            .psel_i    (psel[i]),
            .penable_i (penable),
            .pwrite_i  (pwrite),
            .paddr_i   (paddr),
            .pwdata_i  (pwdata),
            .prdata_o  (prdataVec[i]),
            .pready_o  (preadyVec[i]),
            .irq_o     (irq_o[i])
        );
    end

    apbReadMux #(
        .NumTimers  (NumTimers)
    ) apbReadMux_i (
        .psel_i      (psel),
        .prdataVec_i (prdataVec),
        .preadyVec_i (preadyVec),
        .prdata_o    (prdata),
        .pready_o    (pready)
    );

endmodule

`default_nettype wire

/* apbTimerSysPkg.sv */
/*
 * APB timer subsystem package
 * Shared types for bus words, timer register indices and slot numbers.
 */
`default_nettype none

`include "apbTimerSys_consts.svh"

package apbTimerSysPkg;

    // One bus or register word
    typedef logic [`APB_DATA_W-1:0] dataT;

    // Register word index within a timer slot
    typedef logic [`REG_MSB-`REG_LSB:0] regIdxT;

    // Slot number taken from the address
    typedef logic [`SLOT_MSB-`SLOT_LSB:0] slotIdxT;

endpackage

`default_nettype wire

/* apbTimerSys_consts.svh */
/*
 * APB timer subsystem constants
 * Bus widths, APB slot field position, timer register word offsets
 * and the default number of timers on the APB bus.
 */
`ifndef APBTIMERSYS_CONSTS_SVH
`define APBTIMERSYS_CONSTS_SVH

`define APB_DATA_W      32
`define APB_ADDR_W      32

// Slot number lives in HADDR[23:20]
`define SLOT_LSB        20
`define SLOT_MSB        23
`define NUM_SLOTS       16

// Word offset inside a slot
`define REG_LSB         2
`define REG_MSB         4

// Timer register map, word indices
`define REG_TMR         0
`define REG_PRE         1
`define REG_CMP         2
`define REG_OVF         3
`define REG_EN          4
`define REG_IRQEN       5

`define NUM_TIMERS_DEF  4

`endif

/* tbApbTimerSys.sv */
/*
 * Testbench for the APB timer subsystem
 * Runs AHB-Lite transfers into the DUT and checks reset state, register
 * access, unmapped slots, counting, overflow, interrupts and the bridge
 * wait states.
 */
`timescale 1ns/10ps
`default_nettype none

`include "apbTimerSys_consts.svh"

module tbApbTimerSys;

    localparam int NumTimers     = `NUM_TIMERS_DEF;
    localparam int TimeoutCycles = 500;

    logic                   HCLK;
    logic                   HRESETn;
    logic                   hsel;
    apbTimerSysPkg::dataT   haddr;
    logic [1:0]             htrans;
    logic                   hwrite;
    logic                   hready;
    apbTimerSysPkg::dataT   hwdata;
    apbTimerSysPkg::dataT   hrdata;
    logic                   hreadyout;
    logic [NumTimers-1:0]   irq;

    logic [31:0]            lfsr;
    string                  testName;
    apbTimerSysPkg::dataT   preM [NumTimers];
    apbTimerSysPkg::dataT   cmpM [NumTimers];
    apbTimerSysPkg::dataT   enM [NumTimers];
    apbTimerSysPkg::dataT   irqEnM [NumTimers];

    apbTimerSys #(
        .NumTimers  (NumTimers)
    ) apbTimerSys_i (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .hsel_i      (hsel),
        .haddr_i     (haddr),
        .htrans_i    (htrans),
        .hwrite_i    (hwrite),
        .hready_i    (hready),
        .hwdata_i    (hwdata),
        .hrdata_o    (hrdata),
        .hreadyout_o (hreadyout),
        .irq_o       (irq)
    );

    always #10 HCLK = ~HCLK;

    task automatic failStop(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // Two wait states per accepted transfer, mapped slot or not
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        (hsel && hready && htrans[1] && hreadyout) |=> !hreadyout ##1 !hreadyout ##1 hreadyout)
    else failStop("accepted transfer did not take exactly two wait states");

    // Idle bus keeps the slave ready
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        (hreadyout && !(hsel && hready && htrans[1])) |=> hreadyout)
    else failStop("HREADYOUT dropped without an accepted transfer");

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // One LFSR step per bit taken
    task automatic randWord(output apbTimerSysPkg::dataT val);
        for (int i = 0; i < 32; i++) begin
            val[i] = lfsr[0];
            lfsr   = lfsrNext(lfsr);
        end
    endtask

    task automatic checkEq(input string name, input apbTimerSysPkg::dataT exp,
                           input apbTimerSysPkg::dataT act);
        assert (act === exp)
        else failStop($sformatf("FAIL %s expected %08h actual %08h", name, exp, act));
    endtask

    task automatic ahbXfer(input logic write, input int slot, input int idx,
                           input apbTimerSysPkg::dataT wdata,
                           output apbTimerSysPkg::dataT rdata);
        int cnt;
        @(negedge HCLK);
        hsel   = 1'b1;
        haddr  = (apbTimerSysPkg::dataT'(apbTimerSysPkg::slotIdxT'(slot)) << `SLOT_LSB)
               | (apbTimerSysPkg::dataT'(apbTimerSysPkg::regIdxT'(idx)) << `REG_LSB);
        htrans = 2'b10;
        hwrite = write;
        @(negedge HCLK);
        // Data phase, IDLE transfer to the selected slave behind it
        htrans = 2'b00;
        hwrite = 1'b0;
        hwdata = wdata;
        cnt    = 0;
        while (!hreadyout) begin
            if (cnt == TimeoutCycles) begin
                failStop("timeout waiting for HREADYOUT to return high");
            end
            cnt++;
            @(negedge HCLK);
        end
        rdata = hrdata;
    endtask

    task automatic writeReg(input int slot, input int idx, input apbTimerSysPkg::dataT data);
        apbTimerSysPkg::dataT unused;
        ahbXfer(1'b1, slot, idx, data, unused);
    endtask

    task automatic readReg(input int slot, input int idx, output apbTimerSysPkg::dataT data);
        ahbXfer(1'b0, slot, idx, '0, data);
    endtask

    task automatic readCheck(input int slot, input int idx, input apbTimerSysPkg::dataT exp);
        apbTimerSysPkg::dataT rd;
        readReg(slot, idx, rd);
        checkEq($sformatf("%s slot %0d reg %0d", testName, slot, idx), exp, rd);
    endtask

    task automatic checkAll();
        for (int t = 0; t < NumTimers; t++) begin
            readCheck(t, `REG_PRE, preM[t]);
            readCheck(t, `REG_CMP, cmpM[t]);
            readCheck(t, `REG_EN, enM[t]);
            readCheck(t, `REG_IRQEN, irqEnM[t]);
        end
    endtask

    task automatic waitIrq(input int k);
        int cnt;
        cnt = 0;
        while (!irq[k]) begin
            if (cnt == TimeoutCycles) begin
                failStop("timeout waiting for the timer interrupt");
            end
            checkEq({testName, " other irq"}, '0, apbTimerSysPkg::dataT'(irq));
            cnt++;
            @(negedge HCLK);
        end
    endtask

    initial begin
        apbTimerSysPkg::dataT val;
        apbTimerSysPkg::dataT rd;
        int cnt;
        int k;
        HCLK    = 1'b0;
        HRESETn = 1'b0;
        hsel    = 1'b0;
        haddr   = '0;
        htrans  = 2'b00;
        hwrite  = 1'b0;
        hready  = 1'b1;
        hwdata  = '0;
        lfsr    = 32'h9aed8f0b;
        for (int t = 0; t < NumTimers; t++) begin
            preM[t]   = '0;
            cmpM[t]   = '0;
            enM[t]    = '0;
            irqEnM[t] = '0;
        end
        repeat (8) @(negedge HCLK);
        HRESETn = 1'b1;

        testName = "reset";
        checkEq("reset hreadyout", 1, apbTimerSysPkg::dataT'(hreadyout));
        checkEq("reset irq", 0, apbTimerSysPkg::dataT'(irq));
        for (int s = 0; s < NumTimers; s++) begin
            for (int r = 0; r < 8; r++) begin
                readCheck(s, r, '0);
            end
        end

        // Random register values, all slots re-read after each slot
        testName = "regs";
        for (int s = 0; s < NumTimers; s++) begin
            randWord(val);
            writeReg(s, `REG_PRE, val);
            preM[s] = val;
            randWord(val);
            writeReg(s, `REG_CMP, val);
            cmpM[s] = val;
            randWord(val);
            writeReg(s, `REG_EN, val);
            enM[s] = val & 32'h1;
            randWord(val);
            writeReg(s, `REG_IRQEN, val);
            irqEnM[s] = val & 32'h1;
            checkAll();
        end
        for (int s = 0; s < NumTimers; s++) begin
            writeReg(s, `REG_EN, 0);
            writeReg(s, `REG_IRQEN, 0);
            writeReg(s, `REG_OVF, 1);
            enM[s]    = '0;
            irqEnM[s] = '0;
        end
        checkAll();

        testName = "unmapped";
        for (int s = NumTimers; s < `NUM_SLOTS; s++) begin
            randWord(val);
            writeReg(s, `REG_PRE, val);
            randWord(val);
            writeReg(s, `REG_CMP, val);
            writeReg(s, `REG_EN, 1);
            for (int r = 0; r < 8; r++) begin
                readCheck(s, r, '0);
            end
        end
        checkAll();

        // Timer 1 with PRE 1 and CMP 3
        testName = "count";
        k = 1;
        writeReg(k, `REG_PRE, 1);
        writeReg(k, `REG_CMP, 3);
        writeReg(k, `REG_IRQEN, 1);
        writeReg(k, `REG_EN, 1);
        waitIrq(k);
        checkEq("count irq", apbTimerSysPkg::dataT'(1) << k, apbTimerSysPkg::dataT'(irq));
        readCheck(k, `REG_OVF, 1);
        readReg(k, `REG_TMR, rd);
        assert (rd <= 3)
        else failStop($sformatf("FAIL count tmr expected at most %08h actual %08h", 3, rd));

        testName = "count no irq";
        writeReg(k, `REG_EN, 0);
        writeReg(k, `REG_IRQEN, 0);
        writeReg(k, `REG_OVF, 1);
        readCheck(k, `REG_OVF, 0);
        writeReg(k, `REG_EN, 1);
        cnt = 0;
        rd  = '0;
        while (!rd[0]) begin
            if (cnt == TimeoutCycles) begin
                failStop("timeout waiting for the overflow flag");
            end
            cnt++;
            readReg(k, `REG_OVF, rd);
            checkEq("count no irq irq", 0, apbTimerSysPkg::dataT'(irq));
        end

        // Pending flag shows up once enabled, then cleared
        testName = "ovf clear";
        writeReg(k, `REG_IRQEN, 1);
        checkEq("ovf clear irq high", apbTimerSysPkg::dataT'(1) << k,
                apbTimerSysPkg::dataT'(irq));
        writeReg(k, `REG_EN, 0);
        writeReg(k, `REG_OVF, 1);
        readCheck(k, `REG_OVF, 0);
        checkEq("ovf clear irq low", 0, apbTimerSysPkg::dataT'(irq));

        repeat (4) @(negedge HCLK);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
